// ==== tb.f ====
+incdir+include
source/cpu_pkg.sv
source/register_file.sv
source/control_fsm.sv
source/instr_decoder.sv
source/datapath.sv
source/address_unit.sv
source/cpu_top.sv
test/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - files:
      - source/cpu_pkg.sv
      - source/register_file.sv
      - source/control_fsm.sv
      - source/instr_decoder.sv
      - source/datapath.sv
      - source/address_unit.sv
      - source/cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_cpu.sv

// ==== include/cpu_model.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int DUMP_BASE = 8'hf0;   // Final register dump R0..R7
localparam int RT_BASE   = 8'ha0;

logic [WORD_W-1:0]     model_mem [MEM_SIZE];
logic [WORD_W-1:0]     model_regs [8];
bit                    model_taint [8];   // Value came through an LDR
logic [MEM_ADDR_W-1:0] exp_addr [$];
logic [WORD_W-1:0]     exp_data [$];
bit                    exp_from_load [$];
logic [2:0]            exp_status;
int                    exp_halt_cycle = 0;
int                    prog_len = 0;

function automatic logic [WORD_W-1:0] fill_word(int a);
    return {8'(a), ~8'(a)};
endfunction

function automatic logic [WORD_W-1:0] enc_mov_imm(int rn, int imm);
    return {OPC_MOV, MOV_IMM, 3'(rn), 8'(imm)};
endfunction

// Shift bits 4:3 carry random junk the core ignores
function automatic logic [WORD_W-1:0] enc_reg(opcode_e opc, alu_op_e op, int rn, int rd, int rm);
    return {opc, op, 3'(rn), 3'(rd), 2'($urandom), 3'(rm)};
endfunction

function automatic logic [WORD_W-1:0] enc_mem(opcode_e opc, int rn, int rd, int imm5);
    return {opc, ALU_ADD, 3'(rn), 3'(rd), 5'(imm5)};
endfunction

task automatic put_word(logic [WORD_W-1:0] w);
    model_mem[prog_len] = w;
    prog_len++;
endtask

task automatic set_reg(logic [2:0] r, logic [WORD_W-1:0] value, bit from_load);
    model_regs[r]  = value;
    model_taint[r] = from_load;
endtask

task automatic build_program();
    int kind;
    int rn;
    prog_len = 0;
    for (int a = 0; a < MEM_SIZE; a++)
        model_mem[a] = fill_word(a);
    for (int r = 0; r < 8; r++)
        put_word(enc_mov_imm(r, $urandom));
    while (prog_len < 8 + RANDOM_WORDS)
    begin
        kind = $urandom_range(0, 7);
        rn   = $urandom_range(0, 7);
        case (kind)
            0: put_word(enc_mov_imm(rn, $urandom));
            1: put_word(enc_reg(OPC_MOV, MOV_REG, rn, $urandom_range(0, 7), $urandom_range(0, 7)));
            2, 3, 4, 5:
                put_word(enc_reg(OPC_ALU, alu_op_e'(2'(kind - 2)), rn,
                                 $urandom_range(0, 7), $urandom_range(0, 7)));
            default:
            begin
                // Base 0x90..0xaf keeps the access inside 0x80..0xbe
                put_word(enc_mov_imm(rn, $urandom_range(8'h90, 8'haf)));
                put_word(enc_mem(kind == 6 ? OPC_LDR : OPC_STR, rn, $urandom_range(0, 7), $urandom));
            end
        endcase
    end
    put_word(enc_mov_imm(6, RT_BASE));
    put_word(enc_mem(OPC_STR, 6, 5, 3));   // R5 out and back into R2
    put_word(enc_mem(OPC_LDR, 6, 2, 3));
    put_word(enc_mov_imm(7, DUMP_BASE));
    for (int r = 0; r < 8; r++)
        put_word(enc_mem(OPC_STR, 7, r, r));
    put_word({OPC_HALT, 13'd0});
endtask

task automatic run_model();
    logic [WORD_W-1:0]     ir;
    logic [WORD_W-1:0]     a;
    logic [WORD_W-1:0]     b;
    logic [WORD_W-1:0]     diff;
    logic [MEM_ADDR_W-1:0] addr;
    logic [2:0]            rn;
    logic [2:0]            rd;
    logic [2:0]            rm;
    int                    pc;
    int                    cycles;
    int                    sdiff;
    bit                    done;
    pc         = 0;
    cycles     = 1;   // Edge that leaves reset
    done       = 1'b0;
    exp_status = 3'b000;
    while (!done && pc < MEM_SIZE)
    begin
        ir     = model_mem[pc];
        pc++;
        cycles += 4;   // Fetch and decode
        rn     = ir[10:8];
        rd     = ir[7:5];
        rm     = ir[2:0];
        a      = model_regs[rn];
        b      = model_regs[rm];
        addr   = MEM_ADDR_W'(a + {{(WORD_W-5){ir[4]}}, ir[4:0]});
        case (ir[15:13])
            OPC_MOV:
            begin
                if (ir[12:11] == MOV_IMM)
                begin
                    set_reg(rn, {{(WORD_W-8){ir[7]}}, ir[7:0]}, 1'b0);
                    cycles += 1;
                end
                else
                begin
                    set_reg(rd, b, model_taint[rm]);
                    cycles += 3;
                end
            end
            OPC_ALU:
            begin
                diff  = a - b;
                sdiff = int'($signed(a)) - int'($signed(b));   // Exact signed result
                case (ir[12:11])
                    ALU_ADD: set_reg(rd, a + b, model_taint[rn] | model_taint[rm]);
                    ALU_AND: set_reg(rd, a & b, model_taint[rn] | model_taint[rm]);
                    ALU_NOT: set_reg(rd, ~b, model_taint[rm]);
                    ALU_CMP:
                        exp_status = {diff == '0, diff[WORD_W-1],
                                      sdiff >= 2**(WORD_W-1) || sdiff < -(2**(WORD_W-1))};
                endcase
                cycles += (ir[12:11] == ALU_ADD || ir[12:11] == ALU_AND) ? 4 : 3;
            end
            OPC_LDR:
            begin
                set_reg(rd, model_mem[addr], 1'b1);
                cycles += 5;
            end
            OPC_STR:
            begin
                model_mem[addr] = model_regs[rd];
                exp_addr.push_back(addr);
                exp_data.push_back(model_regs[rd]);
                exp_from_load.push_back(model_taint[rd]);
                cycles += 6;
            end
            OPC_HALT:
                done = 1'b1;
            default:
                cycles += 0;   // Straight back to fetch
        endcase
    end
    exp_halt_cycle = cycles;
endtask

`endif

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int          MEM_ADDR_W   = 8;
    localparam int          MEM_SIZE     = 2**MEM_ADDR_W;
    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 5;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          RANDOM_WORDS = 40;
    localparam int          IDLE_CYCLES  = 20;
    localparam int unsigned SEED         = 32'hd7cf_9fec;

    logic                  clk = 1'b0;
    logic                  reset;
    logic [WORD_W-1:0]     mem_rdata;
    logic [MEM_ADDR_W-1:0] mem_addr;
    mem_cmd_e              mem_cmd;
    logic [WORD_W-1:0]     mem_wdata;
    logic [2:0]            status;
    logic                  halted;

    logic [WORD_W-1:0]     mem [MEM_SIZE];
    int                    cycle = 0;
    int                    halt_cycle = -1;
    int                    write_idx = 0;
    int                    loaded_stores = 0;
    bit                    prev_write = 1'b0;
    logic [MEM_ADDR_W-1:0] prev_addr;
    logic [WORD_W-1:0]     prev_data;
    bit                    program_ready = 1'b0;
    int                    errors_reset = 0;
    int                    errors_store = 0;
    int                    errors_load = 0;
    int                    errors_flags = 0;
    int                    errors_halt = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    `include "cpu_model.svh"

    cpu_top #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_cmd   (mem_cmd),
        .mem_wdata (mem_wdata),
        .status    (status),
        .halted    (halted)
    );

    initial
    begin
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    assign mem_rdata = (mem_cmd == MEM_READ) ? mem[mem_addr] : '0;

    always @(posedge clk)
    begin
        if (mem_cmd == MEM_WRITE)
            mem[mem_addr] <= mem_wdata;
    end

    always @(posedge clk)
    begin
        if (reset)
            cycle <= 0;
        else
            cycle <= cycle + 1;
    end

    task automatic check_store();
        assert (write_idx < exp_addr.size())
        else
        begin
            $display("Store of %h to address %h came after the last expected one",
                     mem_wdata, mem_addr);
            errors_store++;
        end
        if (write_idx < exp_addr.size())
        begin
            assert (mem_addr == exp_addr[write_idx])
            else
            begin
                $display("Mismatch mem_addr at store %0d: got %h expected %h",
                         write_idx, mem_addr, exp_addr[write_idx]);
                errors_store++;
            end
            if (exp_from_load[write_idx])
            begin
                loaded_stores++;
                assert (mem_wdata == exp_data[write_idx])
                else
                begin
                    $display("Mismatch mem_wdata at store %0d (loaded value): got %h expected %h",
                             write_idx, mem_wdata, exp_data[write_idx]);
                    errors_load++;
                end
            end
            else
            begin
                assert (mem_wdata == exp_data[write_idx])
                else
                begin
                    $display("Mismatch mem_wdata at store %0d: got %h expected %h",
                             write_idx, mem_wdata, exp_data[write_idx]);
                    errors_store++;
                end
            end
        end
        write_idx++;
    endtask

    // Falling edge monitor
    always @(negedge clk)
    begin
        if (reset)
        begin
            assert (mem_cmd == MEM_NONE)
            else
            begin
                $display("Mismatch mem_cmd in reset: got %h expected %h", mem_cmd, MEM_NONE);
                errors_reset++;
            end
            assert (!halted)
            else
            begin
                $display("Mismatch halted in reset: got %h expected %h", halted, 1'b0);
                errors_reset++;
            end
        end
        else
        begin
            // A store shows for two cycles but counts once
            if (mem_cmd == MEM_WRITE &&
                (!prev_write || mem_addr != prev_addr || mem_wdata != prev_data))
                check_store();
            if (halted && halt_cycle < 0)
                halt_cycle = cycle;
        end
        prev_write = (mem_cmd == MEM_WRITE);
        prev_addr  = mem_addr;
        prev_data  = mem_wdata;
    end

    task automatic report_test(string name, int errors);
        tests_run++;
        if (errors == 0)
        begin
            $display("Test %-16s ok", name);
        end
        else
        begin
            $display("Test %-16s %0d errors", name, errors);
            tests_failed++;
        end
    endtask

    initial
    begin
        int total_errors;
        reset = 1'b1;
        void'($urandom(SEED));
        build_program();
        foreach (mem[a])
            mem[a] = model_mem[a];
        run_model();
        program_ready = 1'b1;
        $display("Program %0d words, %0d stores, halt at cycle %0d",
                 prog_len, exp_addr.size(), exp_halt_cycle);

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;

        @(negedge clk);   // Still in RST
        assert (mem_cmd == MEM_NONE && !halted)
        else
        begin
            $display("Mismatch mem_cmd/halted after reset: got %h/%h expected %h/%h",
                     mem_cmd, halted, MEM_NONE, 1'b0);
            errors_reset++;
        end
        @(negedge clk);
        assert (mem_cmd == MEM_READ)
        else
        begin
            $display("Mismatch mem_cmd at first fetch: got %h expected %h", mem_cmd, MEM_READ);
            errors_reset++;
        end
        assert (mem_addr == '0)
        else
        begin
            $display("Mismatch mem_addr at first fetch: got %h expected %h", mem_addr, 0);
            errors_reset++;
        end
        report_test("reset state", errors_reset);

        wait (halt_cycle >= 0);
        assert (write_idx == exp_addr.size())
        else
        begin
            $display("Only %0d of %0d expected stores were seen", write_idx, exp_addr.size());
            errors_store++;
        end
        report_test("store sequence", errors_store);

        assert (loaded_stores > 0)
        else
        begin
            $display("No store carried a value that came through a load");
            errors_load++;
        end
        report_test("load round-trip", errors_load);

        assert (status == exp_status)
        else
        begin
            $display("Mismatch status: got %h expected %h", status, exp_status);
            errors_flags++;
        end
        report_test("flags", errors_flags);

        assert (halt_cycle == exp_halt_cycle)
        else
        begin
            $display("Mismatch halted rise cycle: got %h expected %h", halt_cycle, exp_halt_cycle);
            errors_halt++;
        end
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk);
            assert (mem_cmd == MEM_NONE && halted)
            else
            begin
                $display("Mismatch mem_cmd/halted after halt: got %h/%h expected %h/%h",
                         mem_cmd, halted, MEM_NONE, 1'b1);
                errors_halt++;
            end
        end
        report_test("halt and timing", errors_halt);

        total_errors = errors_reset + errors_store + errors_load + errors_flags + errors_halt;
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Watchdog sized from the program length
    initial
    begin
        int limit;
        wait (program_ready);
        limit = prog_len * 12 + 100;
        #((RESET_CYCLES + limit) * CLK_PERIOD);
        $display("Watchdog expired, run did not finish within %0d cycles", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top #(
    parameter int MEM_ADDR_W = 8
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire [cpu_pkg::WORD_W-1:0]  mem_rdata,
    output wire [MEM_ADDR_W-1:0]       mem_addr,
    output wire cpu_pkg::mem_cmd_e     mem_cmd,
    output wire [cpu_pkg::WORD_W-1:0]  mem_wdata,
    output wire [2:0]                  status,
    output wire                        halted
);
    import cpu_pkg::*;

    wire opcode_e              opcode;
    wire alu_op_e              op;
    wire nsel_e                nsel;
    wire vsel_e                vsel;
    wire                       asel;
    wire                       bsel;
    wire                       loada;
    wire                       loadb;
    wire                       loadc;
    wire                       loads;
    wire                       write;
    wire                       load_pc;
    wire                       reset_pc;
    wire                       load_ir;
    wire                       load_addr;
    wire                       addr_sel;
    wire [REG_SEL_W-1:0]       reg_num;
    wire [WORD_W-1:0]          sximm8;
    wire [WORD_W-1:0]          sximm5;
    wire [WORD_W-1:0]          c_out;

    control_fsm fsm_i (
        .clk       (clk),
        .reset     (reset),
        .opcode    (opcode),
        .op        (op),
        .nsel      (nsel),
        .vsel      (vsel),
        .asel      (asel),
        .bsel      (bsel),
        .loada     (loada),
        .loadb     (loadb),
        .loadc     (loadc),
        .loads     (loads),
        .write     (write),
        .load_pc   (load_pc),
        .reset_pc  (reset_pc),
        .load_ir   (load_ir),
        .load_addr (load_addr),
        .addr_sel  (addr_sel),
        .mem_cmd   (mem_cmd),
        .halted    (halted)
    );

    instr_decoder dec_i (
        .clk       (clk),
        .load_ir   (load_ir),
        .mem_rdata (mem_rdata),
        .nsel      (nsel),
        .opcode    (opcode),
        .op        (op),
        .reg_num   (reg_num),
        .sximm8    (sximm8),
        .sximm5    (sximm5)
    );

    datapath dp_i (
        .clk       (clk),
        .reset     (reset),
        .reg_num   (reg_num),
        .write     (write),
        .vsel      (vsel),
        .asel      (asel),
        .bsel      (bsel),
        .loada     (loada),
        .loadb     (loadb),
        .loadc     (loadc),
        .loads     (loads),
        .op        (op),
        .sximm8    (sximm8),
        .sximm5    (sximm5),
        .mem_rdata (mem_rdata),
        .c_out     (c_out),
        .b_out     (mem_wdata),   // Store data is Rd held in B
        .status    (status)
    );

    address_unit #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) addr_i (
        .clk       (clk),
        .reset_pc  (reset_pc),
        .load_pc   (load_pc),
        .load_addr (load_addr),
        .addr_sel  (addr_sel),
        .c_in      (c_out),
        .mem_addr  (mem_addr)
    );

endmodule

`default_nettype wire

// ==== source/address_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module address_unit #(
    parameter int MEM_ADDR_W = 8
) (
    input  wire                        clk,
    input  wire                        reset_pc,
    input  wire                        load_pc,
    input  wire                        load_addr,
    input  wire                        addr_sel,
    input  wire [cpu_pkg::WORD_W-1:0]  c_in,
    output logic [MEM_ADDR_W-1:0]      mem_addr
);

    logic [MEM_ADDR_W-1:0] pc;
    logic [MEM_ADDR_W-1:0] data_addr;

    always_ff @(posedge clk)
    begin
        if (reset_pc)
            pc <= '0;
        else if (load_pc)
            pc <= pc + 1'b1;
    end

    // Low bits of the computed Rn + offset
    always_ff @(posedge clk)
    begin
        if (load_addr)
            data_addr <= c_in[MEM_ADDR_W-1:0];
    end

    assign mem_addr = addr_sel ? pc : data_addr;

endmodule

`default_nettype wire

// ==== source/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapath (
    input  wire                            clk,
    input  wire                            reset,
    input  wire [cpu_pkg::REG_SEL_W-1:0]   reg_num,
    input  wire                            write,
    input  wire cpu_pkg::vsel_e            vsel,
    input  wire                            asel,
    input  wire                            bsel,
    input  wire                            loada,
    input  wire                            loadb,
    input  wire                            loadc,
    input  wire                            loads,
    input  wire cpu_pkg::alu_op_e          op,
    input  wire [cpu_pkg::WORD_W-1:0]      sximm8,
    input  wire [cpu_pkg::WORD_W-1:0]      sximm5,
    input  wire [cpu_pkg::WORD_W-1:0]      mem_rdata,
    output logic [cpu_pkg::WORD_W-1:0]     c_out,
    output logic [cpu_pkg::WORD_W-1:0]     b_out,
    output logic [2:0]                     status
);
    import cpu_pkg::*;

    logic [WORD_W-1:0] wb_data;
    logic [WORD_W-1:0] rf_out;
    logic [WORD_W-1:0] a_reg;
    logic [WORD_W-1:0] ain;
    logic [WORD_W-1:0] bin;
    logic [WORD_W-1:0] diff;
    logic [WORD_W-1:0] alu_out;
    logic              zero;
    logic              neg;
    logic              ovf;

    always_comb
    begin
        case (vsel)
            VSEL_IMM8:  wb_data = sximm8;
            VSEL_MDATA: wb_data = mem_rdata;
            default:    wb_data = c_out;
        endcase
    end

    register_file rf_i (
        .clk      (clk),
        .write    (write),
        .reg_num  (reg_num),
        .data_in  (wb_data),
        .data_out (rf_out)
    );

    always_ff @(posedge clk)
    begin
        if (loada)
            a_reg <= rf_out;
        if (loadb)
            b_out <= rf_out;
        if (loadc)
            c_out <= alu_out;
    end

    assign ain  = asel ? '0 : a_reg;
    assign bin  = bsel ? sximm5 : b_out;
    assign diff = ain - bin;

    always_comb
    begin
        case (op)
            ALU_ADD: alu_out = ain + bin;
            ALU_CMP: alu_out = diff;
            ALU_AND: alu_out = ain & bin;
            default: alu_out = ~bin;   // MVN
        endcase
    end

    // Flags always come from A - B
    assign zero = (diff == '0);
    assign neg  = diff[WORD_W-1];
    assign ovf  = (ain[WORD_W-1] != bin[WORD_W-1]) && (diff[WORD_W-1] != ain[WORD_W-1]);

    always_ff @(posedge clk)
    begin
        if (reset)
            status <= '0;
        else if (loads)
            status <= {zero, neg, ovf};   // Z in bit 2, V in bit 0
    end

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  wire                            clk,
    input  wire                            load_ir,
    input  wire [cpu_pkg::WORD_W-1:0]      mem_rdata,
    input  wire cpu_pkg::nsel_e            nsel,
    output cpu_pkg::opcode_e               opcode,
    output cpu_pkg::alu_op_e               op,
    output logic [cpu_pkg::REG_SEL_W-1:0]  reg_num,
    output logic [cpu_pkg::WORD_W-1:0]     sximm8,
    output logic [cpu_pkg::WORD_W-1:0]     sximm5
);
    import cpu_pkg::*;

    logic [WORD_W-1:0]    ir;
    logic [REG_SEL_W-1:0] rn;
    logic [REG_SEL_W-1:0] rd;
    logic [REG_SEL_W-1:0] rm;

    always_ff @(posedge clk)
    begin
        if (load_ir)
            ir <= mem_rdata;
    end

    assign opcode = opcode_e'(ir[WORD_W-1 -: 3]);
    assign op     = alu_op_e'(ir[WORD_W-4 -: 2]);

    assign rn = ir[10:8];
    assign rd = ir[7:5];
    assign rm = ir[2:0];   // Shift field 4:3 not supported

    assign sximm8 = {{(WORD_W-8){ir[7]}}, ir[7:0]};
    assign sximm5 = {{(WORD_W-5){ir[4]}}, ir[4:0]};

    always_comb
    begin
        case (nsel)
            NSEL_RD: reg_num = rd;
            NSEL_RM: reg_num = rm;
            default: reg_num = rn;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/control_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_fsm (
    input  wire                clk,
    input  wire                reset,
    input  wire cpu_pkg::opcode_e opcode,
    input  wire cpu_pkg::alu_op_e op,
    output cpu_pkg::nsel_e     nsel,
    output cpu_pkg::vsel_e     vsel,
    output logic               asel,
    output logic               bsel,
    output logic               loada,
    output logic               loadb,
    output logic               loadc,
    output logic               loads,
    output logic               write,
    output logic               load_pc,
    output logic               reset_pc,
    output logic               load_ir,
    output logic               load_addr,
    output logic               addr_sel,
    output cpu_pkg::mem_cmd_e  mem_cmd,
    output logic               halted
);
    import cpu_pkg::*;

    typedef enum logic [4:0] {
        S_RST,
        S_IF1,
        S_IF2,
        S_UPDATE_PC,
        S_DECODE,
        S_WRITE_IMM,
        S_GET_A,
        S_GET_B,
        S_EXEC,
        S_WRITE_REG,
        S_MEM_GET_A,
        S_MEM_ADD,
        S_MEM_ADDR,
        S_LDR_READ,
        S_LDR_WRITE,
        S_STR_GET_B,
        S_STR_PASS,
        S_STR_WRITE,
        S_HALT
    } state_e;

    state_e state;
    state_e next_state;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= S_RST;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = S_IF1;   // Unknown encodings fall back to fetch
        case (state)
            S_RST:       next_state = S_IF1;
            S_IF1:       next_state = S_IF2;
            S_IF2:       next_state = S_UPDATE_PC;
            S_UPDATE_PC: next_state = S_DECODE;
            S_DECODE:
            begin
                case (opcode)
                    OPC_MOV:
                    begin
                        if (op == MOV_IMM)
                            next_state = S_WRITE_IMM;
                        else if (op == MOV_REG)
                            next_state = S_GET_B;
                    end
                    OPC_ALU:  next_state = (op == ALU_NOT) ? S_GET_B : S_GET_A;
                    OPC_LDR:  next_state = S_MEM_GET_A;
                    OPC_STR:  next_state = S_MEM_GET_A;
                    OPC_HALT: next_state = S_HALT;
                    default:  next_state = S_IF1;
                endcase
            end
            S_GET_A:     next_state = S_GET_B;
            S_GET_B:     next_state = S_EXEC;
            S_EXEC:
            begin
                // CMP only updates flags
                if (opcode == OPC_ALU && op == ALU_CMP)
                    next_state = S_IF1;
                else
                    next_state = S_WRITE_REG;
            end
            S_MEM_GET_A: next_state = S_MEM_ADD;
            S_MEM_ADD:   next_state = S_MEM_ADDR;
            S_MEM_ADDR:  next_state = (opcode == OPC_STR) ? S_STR_GET_B : S_LDR_READ;
            S_LDR_READ:  next_state = S_LDR_WRITE;
            S_STR_GET_B: next_state = S_STR_PASS;
            S_STR_PASS:  next_state = S_STR_WRITE;
            S_HALT:      next_state = S_HALT;
            default:     next_state = S_IF1;
        endcase
    end

    always_comb
    begin
        nsel      = NSEL_RN;
        vsel      = VSEL_C;
        asel      = 1'b0;
        bsel      = 1'b0;
        loada     = 1'b0;
        loadb     = 1'b0;
        loadc     = 1'b0;
        loads     = 1'b0;
        write     = 1'b0;
        load_pc   = 1'b0;
        reset_pc  = 1'b0;
        load_ir   = 1'b0;
        load_addr = 1'b0;
        addr_sel  = 1'b0;
        mem_cmd   = MEM_NONE;
        halted    = 1'b0;
        case (state)
            S_RST:
                reset_pc = 1'b1;
            S_IF1:
            begin
                addr_sel = 1'b1;
                mem_cmd  = MEM_READ;
            end
            S_IF2:
            begin
                addr_sel = 1'b1;
                mem_cmd  = MEM_READ;
                load_ir  = 1'b1;   // Read data settled by now
            end
            S_UPDATE_PC:
                load_pc = 1'b1;
            S_WRITE_IMM:
            begin
                vsel  = VSEL_IMM8;
                write = 1'b1;
            end
            S_GET_A:
                loada = 1'b1;
            S_GET_B:
            begin
                nsel  = NSEL_RM;
                loadb = 1'b1;
            end
            S_EXEC:
            begin
                asel  = (opcode == OPC_MOV);   // MOV is 0 + Rm
                loadc = 1'b1;
                loads = (opcode == OPC_ALU && op == ALU_CMP);
            end
            S_WRITE_REG:
            begin
                nsel  = NSEL_RD;
                write = 1'b1;
            end
            S_MEM_GET_A:
                loada = 1'b1;
            S_MEM_ADD:
            begin
                bsel  = 1'b1;   // Rn + sximm5
                loadc = 1'b1;
            end
            S_MEM_ADDR:
                load_addr = 1'b1;
            S_LDR_READ:
                mem_cmd = MEM_READ;
            S_LDR_WRITE:
            begin
                mem_cmd = MEM_READ;
                nsel    = NSEL_RD;
                vsel    = VSEL_MDATA;
                write   = 1'b1;
            end
            S_STR_GET_B:
            begin
                nsel  = NSEL_RD;
                loadb = 1'b1;
            end
            S_STR_PASS:
            begin
                asel    = 1'b1;
                loadc   = 1'b1;
                mem_cmd = MEM_WRITE;
            end
            S_STR_WRITE:
                mem_cmd = MEM_WRITE;
            S_HALT:
                halted = 1'b1;
            default:
                halted = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  wire                            clk,
    input  wire                            write,
    input  wire [cpu_pkg::REG_SEL_W-1:0]   reg_num,
    input  wire [cpu_pkg::WORD_W-1:0]      data_in,
    output logic [cpu_pkg::WORD_W-1:0]     data_out
);
    import cpu_pkg::*;

    logic [WORD_W-1:0] regs [2**REG_SEL_W];

    always_ff @(posedge clk)
    begin
        if (write)
            regs[reg_num] <= data_in;
    end

    // Same number serves read and write
    assign data_out = regs[reg_num];

endmodule

`default_nettype wire

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_SEL_W = 3;

    // Instruction class, bits 15:13
    typedef enum logic [2:0] {
        OPC_LDR  = 3'b011,
        OPC_STR  = 3'b100,
        OPC_ALU  = 3'b101,
        OPC_MOV  = 3'b110,
        OPC_HALT = 3'b111
    } opcode_e;

    // Bits 12:11
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_CMP = 2'b01,
        ALU_AND = 2'b10,
        ALU_NOT = 2'b11
    } alu_op_e;

    // MOV reuses the op field to pick its form
    localparam alu_op_e MOV_REG = ALU_ADD;
    localparam alu_op_e MOV_IMM = ALU_AND;

    typedef enum logic [1:0] {
        MEM_READ  = 2'b01,
        MEM_WRITE = 2'b10,
        MEM_NONE  = 2'b11
    } mem_cmd_e;

    typedef enum logic [1:0] {
        NSEL_RN = 2'b00,
        NSEL_RD = 2'b01,
        NSEL_RM = 2'b10
    } nsel_e;

    // Register file write-back source
    typedef enum logic [1:0] {
        VSEL_C     = 2'b00,
        VSEL_IMM8  = 2'b10,
        VSEL_MDATA = 2'b11
    } vsel_e;

endpackage

`default_nettype wire
